// File: csr_pkg.sv
package csr_pkg;

	localparam int ADDR_BITS = 8;

	// register map
	localparam logic [ADDR_BITS-1:0] ADDR_SLOT = 8'd0;
	localparam logic [ADDR_BITS-1:0] ADDR_PID = 8'd1;
	localparam logic [ADDR_BITS-1:0] ADDR_COUNT = 8'd2;
	localparam logic [ADDR_BITS-1:0] ADDR_PAYLOAD_BASE = 8'd64;

	// pattern returned for unmapped reads
	localparam logic [15:0] UNMAPPED_TAG = 16'hE000;

	// per-slot filter setup
	typedef struct packed {
		logic en;
		logic [12:0] pid;
	} pid_cfg_t;

	// pid register layout
	typedef struct packed {
		logic [14:0] rsvd_hi;
		logic en;
		logic [2:0] rsvd_lo;
		logic [12:0] pid;
	} pid_word_t;

	// lane 0 is the least significant byte
	typedef union packed {
		pid_word_t cfg;
		logic [3:0][7:0] lane;
	} csr_word_u;

endpackage

// File: run_sim.sh
#!/bin/bash
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module tb_ts_remux \
	-f ts_remux_top.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -qF "All tests passed!" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_ts_remux.sv
`timescale 1ns/1ns

module tb_ts_remux import ts_pkg::*, csr_pkg::*; ();

	localparam int FILTER_NUM = 4;
	localparam int MONITOR_NUM = 1;
	localparam int IN_CREDITS = 8;
	localparam int OUT_CREDITS = 4;

	// table row kinds
	localparam logic [2:0] K_WR = 3'd0;
	localparam logic [2:0] K_RD = 3'd1;
	localparam logic [2:0] K_PKT = 3'd2;
	localparam logic [2:0] K_DLY = 3'd3;
	localparam logic [2:0] K_END = 3'd4;

	typedef struct packed {
		logic [2:0] kind;
		logic [7:0] addr;
		logic [31:0] data;
		logic [31:0] exp_word;
	} row_t;

	logic clk = 1'b0;
	logic rst_n;
	logic wen;
	logic [ADDR_BITS-1:0] waddr;
	logic [31:0] wdata;
	logic ren;
	logic [ADDR_BITS-1:0] raddr;
	logic [31:0] rdata;
	logic in_valid;
	ts_byte_t in_byte;
	logic in_credit;
	logic out_valid;
	ts_byte_t out_byte;
	logic out_credit = 1'b0;

	row_t rows[$];
	ts_byte_t exp_q[$];
	int due_q[$];
	ts_byte_t exp_b;

	// register model of the slots and payload buffer
	int m_slot = 0;
	logic m_en [FILTER_NUM] = '{default: 1'b0};
	logic [12:0] m_pid [FILTER_NUM] = '{default: 13'h0};
	logic [31:0] m_pay [PAYLOAD_WORDS];

	int n_rows = 0;
	int n_pkts = 0;
	int err_cnt = 0;
	int mon_err = 0;
	int test_base = 0;
	int tests_done = 0;
	int sink_max = 0;
	int cyc = 0;
	int in_sent = 0;
	int in_ret = 0;
	int out_cnt = 0;
	int out_ret = 0;
	int last_due = 0;
	int sink_delay;
	logic [31:0] lcg_state = 32'd87416;

	ts_remux_top #(
		.FILTER_NUM(FILTER_NUM),
		.MONITOR_NUM(MONITOR_NUM),
		.IN_CREDITS(IN_CREDITS),
		.OUT_CREDITS(OUT_CREDITS)
	) u_ts_remux_top (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] fill_word(logic [7:0] a);
		return {a, ~a, a ^ 8'h5a, a + 8'h33};
	endfunction

	function automatic ts_byte_t pkt_byte(logic [12:0] pid, int n, int i);
		ts_byte_t b;
		b.sync = (i == 0);
		case (i)
			0: b.data = 8'h47;
			1: b.data = {3'b010, pid[12:8]};
			2: b.data = pid[7:0];
			3: b.data = 8'h10 | 8'(n & 15);
			default: b.data = 8'(i * 7 + n * 13);
		endcase
		return b;
	endfunction

	task automatic add_row(logic [2:0] kind, logic [7:0] addr, logic [31:0] data,
			logic [31:0] exp_word);
		rows.push_back(row_t'{kind, addr, data, exp_word});
	endtask

	task automatic check_word(csr_word_u got, csr_word_u exp, logic [7:0] addr);
		if (got !== exp) begin
			$display("Mismatch at %0t: read of address %0d gave %h, expected %h",
				$time, addr, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_byte(ts_byte_t got, ts_byte_t exp, int idx);
		if (got !== exp) begin
			$display("Mismatch at %0t: byte %0d sync %0b data %h, expected sync %0b data %h",
				$time, idx, got.sync, got.data, exp.sync, exp.data);
			mon_err++;
		end
	endtask

	task automatic write_reg(logic [7:0] a, logic [31:0] d);
		csr_word_u word;
		word = d;
		@(posedge clk);
		wen <= 1'b1;
		waddr <= a;
		wdata <= d;
		@(posedge clk);
		wen <= 1'b0;
		// out of range slot numbers are dropped
		if (a == ADDR_SLOT && d < 32'(FILTER_NUM)) begin
			m_slot = int'(d);
		end else if (a == ADDR_PID) begin
			m_en[m_slot] = word.cfg.en;
			m_pid[m_slot] = word.cfg.pid;
		end else if (a >= ADDR_PAYLOAD_BASE && a < ADDR_PAYLOAD_BASE + 8'(PAYLOAD_WORDS)) begin
			m_pay[int'(a - ADDR_PAYLOAD_BASE)] = d;
		end
	endtask

	task automatic read_reg(logic [7:0] a, logic [31:0] e);
		@(posedge clk);
		ren <= 1'b1;
		raddr <= a;
		@(posedge clk);
		ren <= 1'b0;
		@(negedge clk);
		check_word(rdata, e, a);
	endtask

	task automatic send_packet(logic [12:0] pid);
		ts_byte_t b;
		logic repl;
		int i;
		int w;
		repl = 1'b0;
		for (i = MONITOR_NUM; i < FILTER_NUM; i++) begin
			repl = repl || (m_en[i] && m_pid[i] == pid);
		end
		for (i = 0; i < PACK_BYTES; i++) begin
			b = pkt_byte(pid, n_pkts, i);
			if (repl && i >= HDR_BYTES) begin
				w = i - HDR_BYTES;
				b.data = m_pay[w / 4][8 * (w % 4) +: 8];
			end
			exp_q.push_back(b);
		end
		i = 0;
		while (i < PACK_BYTES) begin
			@(posedge clk);
			// credits held = start credits minus bytes not yet returned
			if (in_sent + int'(in_valid) - in_ret < IN_CREDITS) begin
				in_valid <= 1'b1;
				in_byte <= pkt_byte(pid, n_pkts, i);
				i++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		n_pkts++;
	endtask

	task automatic end_test(int t);
		int errs;
		@(negedge clk);
		while (exp_q.size() != 0 || due_q.size() != 0 || out_credit) begin
			@(negedge clk);
		end
		if (out_cnt != in_sent) begin
			$display("%0d bytes were sent but %0d came out", in_sent, out_cnt);
			err_cnt++;
		end
		if (in_ret != out_cnt) begin
			$display("%0d input credits came back for %0d output bytes", in_ret, out_cnt);
			err_cnt++;
		end
		errs = err_cnt + mon_err - test_base;
		test_base = err_cnt + mon_err;
		tests_done++;
		if (errs == 0) begin
			$display("test %0d: ok", t);
		end else begin
			$display("test %0d: %0d errors", t, errs);
		end
	endtask

	task automatic build_table();
		int i;
		add_row(K_RD, ADDR_SLOT, 32'h0, 32'h0);
		add_row(K_RD, ADDR_PID, 32'h0, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'h0);
		add_row(K_RD, 8'h05, 32'h0, 32'hE000_0005);
		add_row(K_RD, 8'h6E, 32'h0, 32'hE000_006E);
		add_row(K_END, 8'h0, 32'd1, 32'h0);
		// no slot enabled yet
		add_row(K_PKT, 8'h0, 32'h0100, 32'h0);
		add_row(K_PKT, 8'h0, 32'h1FFF, 32'h0);
		add_row(K_END, 8'h0, 32'd2, 32'h0);
		for (i = 0; i < PAYLOAD_WORDS; i++) begin
			add_row(K_WR, ADDR_PAYLOAD_BASE + 8'(i), fill_word(ADDR_PAYLOAD_BASE + 8'(i)), 32'h0);
		end
		add_row(K_RD, 8'd64, 32'h0, fill_word(8'd64));
		add_row(K_RD, 8'd109, 32'h0, fill_word(8'd109));
		add_row(K_WR, ADDR_SLOT, 32'd2, 32'h0);
		add_row(K_WR, ADDR_PID, 32'h0001_0123, 32'h0);
		add_row(K_RD, ADDR_PID, 32'h0, 32'h0001_0123);
		add_row(K_PKT, 8'h0, 32'h0123, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0124, 32'h0);
		add_row(K_END, 8'h0, 32'd3, 32'h0);
		// slot 0 monitors while slot 3 matches but is disabled
		add_row(K_WR, ADDR_SLOT, 32'd0, 32'h0);
		add_row(K_WR, ADDR_PID, 32'h0001_0200, 32'h0);
		add_row(K_WR, ADDR_SLOT, 32'd3, 32'h0);
		add_row(K_WR, ADDR_PID, 32'h0000_0200, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0200, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0200, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0123, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0200, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'd0);
		add_row(K_WR, ADDR_SLOT, 32'd0, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'd3);
		add_row(K_WR, ADDR_SLOT, 32'd2, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'd2);
		add_row(K_WR, ADDR_SLOT, 32'd1, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'd0);
		add_row(K_END, 8'h0, 32'd4, 32'h0);
		add_row(K_DLY, 8'h0, 32'd7, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0123, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0555, 32'h0);
		add_row(K_DLY, 8'h0, 32'd20, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0123, 32'h0);
		add_row(K_DLY, 8'h0, 32'd1, 32'h0);
		add_row(K_PKT, 8'h0, 32'h0777, 32'h0);
		add_row(K_END, 8'h0, 32'd5, 32'h0);
		// slot 1 stays selected across bad selects
		add_row(K_RD, ADDR_SLOT, 32'h0, 32'd1);
		add_row(K_WR, ADDR_SLOT, 32'd4, 32'h0);
		add_row(K_RD, ADDR_SLOT, 32'h0, 32'd1);
		add_row(K_WR, ADDR_SLOT, 32'hFF, 32'h0);
		add_row(K_WR, ADDR_PID, 32'h0001_0ABC, 32'h0);
		add_row(K_WR, ADDR_SLOT, 32'd0, 32'h0);
		add_row(K_RD, ADDR_PID, 32'h0, 32'h0001_0200);
		add_row(K_WR, ADDR_SLOT, 32'd1, 32'h0);
		add_row(K_RD, ADDR_PID, 32'h0, 32'h0001_0ABC);
		add_row(K_PKT, 8'h0, 32'h0ABC, 32'h0);
		add_row(K_RD, ADDR_COUNT, 32'h0, 32'd1);
		add_row(K_END, 8'h0, 32'd6, 32'h0);
	endtask

	// sink and stream bookkeeping
	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
			// a credit for a byte never taken would let the upstream overrun the FIFO
			if (in_credit && in_ret >= in_sent) begin
				$display("Input credit at %0t returned for a byte the DUT never took", $time);
				mon_err++;
			end
			if (in_valid) begin
				in_sent <= in_sent + 1;
			end
			if (in_credit) begin
				in_ret <= in_ret + 1;
			end
			if (out_valid) begin
				if (out_cnt - out_ret >= OUT_CREDITS) begin
					$display("More than %0d output bytes outstanding at %0t", OUT_CREDITS, $time);
					mon_err++;
				end
				if (exp_q.size() == 0) begin
					$display("Output byte at %0t arrived with nothing expected", $time);
					mon_err++;
				end else begin
					exp_b = exp_q.pop_front();
					check_byte(out_byte, exp_b, out_cnt);
				end
				out_cnt <= out_cnt + 1;
				sink_delay = int'((lcg_next() >> 16) % 32'(sink_max + 1));
				// credit pulses go out one per cycle in order
				last_due = (cyc + sink_delay > last_due) ? cyc + sink_delay : last_due + 1;
				due_q.push_back(last_due);
			end
			if (out_credit) begin
				out_ret <= out_ret + 1;
			end
			if (due_q.size() != 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				out_credit <= 1'b1;
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	initial begin
		wait (n_rows != 0);
		#(n_rows * PACK_BYTES * 8 * 10);
		$display("Timeout after %0d cycles, the DUT stopped delivering bytes",
			n_rows * PACK_BYTES * 8);
		$display("Test failures found");
		$finish;
	end

	initial begin
		rst_n <= 1'b0;
		wen <= 1'b0;
		waddr <= '0;
		wdata <= '0;
		ren <= 1'b0;
		raddr <= '0;
		in_valid <= 1'b0;
		in_byte <= '0;
		build_table();
		n_rows = rows.size();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		foreach (rows[r]) begin
			case (rows[r].kind)
				K_WR: write_reg(rows[r].addr, rows[r].data);
				K_RD: read_reg(rows[r].addr, rows[r].exp_word);
				K_PKT: send_packet(rows[r].data[12:0]);
				K_DLY: sink_max <= int'(rows[r].data);
				default: end_test(int'(rows[r].data));
			endcase
		end
		$display("%0d tests run, %0d errors", tests_done, err_cnt + mon_err);
		if (err_cnt + mon_err == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: ts_csr_decode.sv
`timescale 1ns/1ns

module ts_csr_decode import ts_pkg::*, csr_pkg::*; #(
	parameter int FILTER_NUM = 4,
	parameter int ADDR_BITS = 8
) (
	input logic clk,
	input logic rst_n,

	input logic wen,
	input logic [ADDR_BITS-1:0] waddr,
	input logic [31:0] wdata,

	input logic ren,
	input logic [ADDR_BITS-1:0] raddr,
	output logic [31:0] rdata,

	input logic [31:0] match_count [FILTER_NUM],
	input logic [PAYLOAD_IDX_BITS-1:0] payload_idx,

	output pid_cfg_t slot_cfg [FILTER_NUM],
	output logic [31:0] payload_word
);

	localparam int SLOT_BITS = (FILTER_NUM > 1) ? $clog2(FILTER_NUM) : 1;
	localparam logic [ADDR_BITS-1:0] PAY_BASE = ADDR_BITS'(ADDR_PAYLOAD_BASE);
	localparam logic [ADDR_BITS-1:0] PAY_SIZE = ADDR_BITS'(PAYLOAD_WORDS);

	logic [SLOT_BITS-1:0] cur_slot;
	logic [3:0][7:0] payload_mem [PAYLOAD_WORDS];

	csr_word_u wr_word;
	csr_word_u rd_word;

	logic [ADDR_BITS-1:0] w_off;
	logic [ADDR_BITS-1:0] r_off;
	logic w_is_payload;
	logic r_is_payload;

	assign wr_word = wdata;

	// payload window decode
	assign w_off = waddr - PAY_BASE;
	assign r_off = raddr - PAY_BASE;
	assign w_is_payload = (waddr >= PAY_BASE) && (w_off < PAY_SIZE);
	assign r_is_payload = (raddr >= PAY_BASE) && (r_off < PAY_SIZE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cur_slot <= '0;
			for (int i = 0; i < FILTER_NUM; i++) begin
				slot_cfg[i] <= '0;
			end
		end else if (wen) begin
			case (waddr)
				ADDR_SLOT: begin
					// out of range selects are dropped
					if (wdata < 32'(FILTER_NUM)) begin
						cur_slot <= wdata[SLOT_BITS-1:0];
					end
				end
				ADDR_PID: begin
					slot_cfg[cur_slot].en <= wr_word.cfg.en;
					slot_cfg[cur_slot].pid <= wr_word.cfg.pid;
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wen && w_is_payload) begin
			payload_mem[w_off[PAYLOAD_IDX_BITS-1:0]] <= wr_word.lane;
		end
	end

	// replacement path reads the buffer directly
	assign payload_word = payload_mem[payload_idx];

	always_comb begin
		rd_word = '0;
		if (r_is_payload) begin
			rd_word.lane = payload_mem[r_off[PAYLOAD_IDX_BITS-1:0]];
		end else begin
			case (raddr)
				ADDR_SLOT: begin
					rd_word = 32'(cur_slot);
				end
				ADDR_PID: begin
					rd_word.cfg.en = slot_cfg[cur_slot].en;
					rd_word.cfg.pid = slot_cfg[cur_slot].pid;
				end
				ADDR_COUNT: begin
					rd_word = match_count[cur_slot];
				end
				default: begin
					rd_word = {UNMAPPED_TAG, 16'(raddr)};
				end
			endcase
		end
	end

	// read data one cycle after ren
	always_ff @(posedge clk) begin
		if (ren) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: ts_out_stage.sv
`timescale 1ns/1ns

module ts_out_stage import ts_pkg::*; #(
	parameter int IN_CREDITS = 8,
	parameter int OUT_CREDITS = 4
) (
	input logic clk,
	input logic rst_n,

	input logic fifo_valid,
	input ts_byte_t fifo_byte,

	input logic out_credit,
	output logic in_credit,
	output logic out_valid,
	output ts_byte_t out_byte
);

	localparam int PTR_BITS = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
	localparam int CNT_BITS = $clog2(IN_CREDITS + 1);
	localparam int CRED_BITS = $clog2(OUT_CREDITS + 1);
	localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(IN_CREDITS - 1);

	ts_byte_t fifo_mem [IN_CREDITS];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CRED_BITS-1:0] credits;

	logic empty;
	logic pop;
	logic push_mem;
	logic pop_mem;
	ts_byte_t head;

	// empty fifo lets the incoming byte straight through
	assign empty = (count == '0);
	assign head = empty ? fifo_byte : fifo_mem[rd_ptr];
	assign pop = (!empty || fifo_valid) && (credits != '0);
	assign pop_mem = pop && !empty;
	assign push_mem = fifo_valid && !(pop && empty);

	always_ff @(posedge clk) begin
		if (push_mem) begin
			fifo_mem[wr_ptr] <= fifo_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_mem) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_mem) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_BITS'(push_mem) - CNT_BITS'(pop_mem);
		end
	end

	// send and return may coincide
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= CRED_BITS'(OUT_CREDITS);
			out_valid <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			credits <= credits - CRED_BITS'(pop) + CRED_BITS'(out_credit);
			out_valid <= pop;
			in_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_byte <= head;
		end
	end

endmodule

// File: ts_pid_match.sv
`timescale 1ns/1ns

module ts_pid_match import ts_pkg::*, csr_pkg::*; #(
	parameter int FILTER_NUM = 4,
	parameter int MONITOR_NUM = 1
) (
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	input ts_byte_t in_byte,

	input pid_cfg_t slot_cfg [FILTER_NUM],
	input logic [31:0] payload_word,
	output logic [PAYLOAD_IDX_BITS-1:0] payload_idx,
	output logic [31:0] match_count [FILTER_NUM],

	output logic fifo_valid,
	output ts_byte_t fifo_byte
);

	// low slots only count
	localparam logic [FILTER_NUM-1:0] MON_MASK = FILTER_NUM'((1 << MONITOR_NUM) - 1);
	localparam logic [POS_BITS-1:0] HDR_END = POS_BITS'(HDR_BYTES);
	localparam logic [POS_BITS-1:0] PACK_END = POS_BITS'(PACK_BYTES);

	logic [POS_BITS-1:0] pos;
	logic [POS_BITS-1:0] cur_pos;
	logic [POS_BITS-1:0] pay_off;
	logic [4:0] pid_hi;
	logic [12:0] pid;
	logic [FILTER_NUM-1:0] hit;
	logic repl;
	logic replace_now;
	logic [1:0] lane;
	logic [7:0] out_data;

	always_comb begin
		cur_pos = in_byte.sync ? '0 : pos;
		pid = {pid_hi, in_byte.data};
		for (int i = 0; i < FILTER_NUM; i++) begin
			hit[i] = slot_cfg[i].en && (slot_cfg[i].pid == pid);
		end
	end

	// payload position as word then lane
	always_comb begin
		pay_off = cur_pos - HDR_END;
		lane = pay_off[1:0];
		replace_now = repl && (cur_pos >= HDR_END) && (cur_pos < PACK_END);
		payload_idx = replace_now ? pay_off[2 +: PAYLOAD_IDX_BITS] : '0;
		out_data = replace_now ? payload_word[{lane, 3'b000} +: 8] : in_byte.data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos <= '0;
			pid_hi <= '0;
			repl <= 1'b0;
			fifo_valid <= 1'b0;
			for (int i = 0; i < FILTER_NUM; i++) begin
				match_count[i] <= '0;
			end
		end else begin
			fifo_valid <= in_valid;
			if (in_valid) begin
				// hold at packet end until the next sync
				if (cur_pos < PACK_END) begin
					pos <= cur_pos + 1'b1;
				end
				if (cur_pos == POS_BITS'(1)) begin
					pid_hi <= in_byte.data[4:0];
				end
				if (cur_pos == POS_BITS'(2)) begin
					repl <= |(hit & ~MON_MASK);
					for (int i = 0; i < FILTER_NUM; i++) begin
						if (hit[i]) begin
							match_count[i] <= match_count[i] + 32'd1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			fifo_byte.sync <= in_byte.sync;
			fifo_byte.data <= out_data;
		end
	end

endmodule

// File: ts_pkg.sv
package ts_pkg;

	// transport packet geometry
	localparam int PACK_BYTES = 188;
	localparam int HDR_BYTES = 4;

	// shared payload buffer holds one packet payload in 32-bit words
	localparam int PAYLOAD_WORDS = (PACK_BYTES - HDR_BYTES) / 4;
	localparam int PAYLOAD_IDX_BITS = $clog2(PAYLOAD_WORDS);

	// byte position within a packet
	localparam int POS_BITS = $clog2(PACK_BYTES + 1);

	// one stream byte with a sync flag on byte 0 of a packet
	typedef struct packed {
		logic sync;
		logic [7:0] data;
	} ts_byte_t;

endpackage

// File: ts_remux_top.f
ts_pkg.sv
csr_pkg.sv
ts_csr_decode.sv
ts_pid_match.sv
ts_out_stage.sv
ts_remux_top.sv
tb_ts_remux.sv

// File: ts_remux_top.sv
`timescale 1ns/1ns

module ts_remux_top import ts_pkg::*, csr_pkg::*; #(
	parameter int FILTER_NUM = 4,
	parameter int MONITOR_NUM = 1,
	parameter int IN_CREDITS = 8,
	parameter int OUT_CREDITS = 4
) (
	input logic clk,
	input logic rst_n,

	input logic wen,
	input logic [ADDR_BITS-1:0] waddr,
	input logic [31:0] wdata,
	input logic ren,
	input logic [ADDR_BITS-1:0] raddr,
	output logic [31:0] rdata,

	input logic in_valid,
	input ts_byte_t in_byte,
	output logic in_credit,

	output logic out_valid,
	output ts_byte_t out_byte,
	input logic out_credit
);

	pid_cfg_t slot_cfg [FILTER_NUM];
	logic [31:0] match_count [FILTER_NUM];
	logic [PAYLOAD_IDX_BITS-1:0] payload_idx;
	logic [31:0] payload_word;
	logic fifo_valid;
	ts_byte_t fifo_byte;

	ts_csr_decode #(
		.FILTER_NUM(FILTER_NUM),
		.ADDR_BITS(ADDR_BITS)
	) u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.match_count(match_count),
		.payload_idx(payload_idx),
		.slot_cfg(slot_cfg),
		.payload_word(payload_word)
	);

	ts_pid_match #(
		.FILTER_NUM(FILTER_NUM),
		.MONITOR_NUM(MONITOR_NUM)
	) u_match (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_byte(in_byte),
		.slot_cfg(slot_cfg),
		.payload_word(payload_word),
		.payload_idx(payload_idx),
		.match_count(match_count),
		.fifo_valid(fifo_valid),
		.fifo_byte(fifo_byte)
	);

	ts_out_stage #(
		.IN_CREDITS(IN_CREDITS),
		.OUT_CREDITS(OUT_CREDITS)
	) u_out (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_valid(fifo_valid),
		.fifo_byte(fifo_byte),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_byte(out_byte)
	);

endmodule
